/* compile.f */
rtl/frontend_pkg.sv
rtl/inst_decoder.sv
rtl/direction_predictor.sv
rtl/branch_target_buffer.sv
rtl/next_pc_logic.sv
rtl/dispatch_stage.sv
rtl/frontend_top.sv
test/frontend_tb.sv

/* rtl/branch_target_buffer.sv */
//////////////////////////////////////////////////
// direct-mapped branch target buffer
//////////////////////////////////////////////////

`timescale 1ns/1ps

module branch_target_buffer import frontend_pkg::*; #(
	parameter int btb_entries = 16
) (
	input  logic            clock,
	input  logic            reset,
	input  logic [xlen-1:0] lookup_pc,
	output logic            hit,
	output logic [xlen-1:0] target,
	input  logic            write_valid,
	input  logic [xlen-1:0] write_pc,
	input  logic [xlen-1:0] write_target
);

	localparam int idx_bits = $clog2(btb_entries);
	localparam int tag_bits = xlen - idx_bits - 2;

	logic                entry_valid [btb_entries];
	logic [tag_bits-1:0] entry_tag   [btb_entries];
	logic [xlen-1:0]     entry_target[btb_entries];

	logic [idx_bits-1:0] rd_idx;
	logic [idx_bits-1:0] wr_idx;

	assign rd_idx = lookup_pc[idx_bits+1:2];
	assign wr_idx = write_pc[idx_bits+1:2];

	// combinational read
	assign hit    = entry_valid[rd_idx] && (entry_tag[rd_idx] == lookup_pc[xlen-1:idx_bits+2]);
	assign target = entry_target[rd_idx];

	// valid bits
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < btb_entries; i++)
				entry_valid[i] <= 1'b0;
		end else if (write_valid)
			entry_valid[wr_idx] <= 1'b1;
	end

	// tag/target payload, newest write wins
	always_ff @(posedge clock) begin
		if (write_valid) begin
			entry_tag[wr_idx]    <= write_pc[xlen-1:idx_bits+2];
			entry_target[wr_idx] <= write_target;
		end
	end

endmodule

/* rtl/direction_predictor.sv */
//////////////////////////////////////////////////
// bimodal direction predictor, 2-bit counters
//////////////////////////////////////////////////

`timescale 1ns/1ps

module direction_predictor import frontend_pkg::*; #(
	parameter int pht_entries = 64,
	localparam int idx_bits = $clog2(pht_entries)
) (
	input  logic                clock,
	input  logic                reset,
	input  logic [xlen-1:0]     fetch_pc,
	output logic [idx_bits-1:0] dirp_idx,
	output logic                predict_taken,
	input  logic                train_valid,
	input  logic [idx_bits-1:0] train_idx,
	input  logic                train_taken
);

	logic [1:0] pht [pht_entries];

	// word index, skip byte offset
	assign dirp_idx      = fetch_pc[idx_bits+1:2];
	assign predict_taken = pht[dirp_idx][1];

	always_ff @(posedge clock) begin
		if (reset) begin
			// weakly not-taken
			for (int i = 0; i < pht_entries; i++)
				pht[i] <= 2'b01;
		end else if (train_valid) begin
			// saturate at both ends
			if (train_taken && pht[train_idx] != 2'b11)
				pht[train_idx] <= pht[train_idx] + 2'd1;
			else if (!train_taken && pht[train_idx] != 2'b00)
				pht[train_idx] <= pht[train_idx] - 2'd1;
		end
	end

	// execute must hand back the index it got at fetch
	assert property (@(posedge clock) disable iff (reset)
		train_valid |-> !$isunknown(train_idx));

endmodule

/* rtl/dispatch_stage.sv */
//////////////////////////////////////////////////
// pc register, fetch half-select, credit counter
// halt state and decoded dispatch
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dispatch_stage import frontend_pkg::*; #(
	parameter int dispatch_credits = 4,
	parameter int pht_entries = 64,
	localparam int dirp_bits = $clog2(pht_entries)
) (
	input  logic                 clock,
	input  logic                 reset,
	output logic [xlen-1:0]      imem_addr,
	input  logic [63:0]          imem_data,
	input  logic                 imem_valid,
	input  logic                 squash,
	input  logic [xlen-1:0]      squash_pc,
	input  logic                 credit_return,
	input  logic [xlen-1:0]      pred_next_pc,
	input  logic                 pred_taken_in,
	input  logic [dirp_bits-1:0] dirp_idx_in,
	output logic [xlen-1:0]      fetch_pc,
	output logic [xlen-1:0]      seq_pc,
	output logic                 is_cond_branch,
	output logic                 is_jump,
	output logic                 disp_valid,
	output logic [xlen-1:0]      disp_pc,
	output logic [xlen-1:0]      disp_npc,
	output logic [31:0]          disp_inst,
	output opa_sel_e             disp_opa_select,
	output opb_sel_e             disp_opb_select,
	output alu_func_e            disp_alu_func,
	output logic [4:0]           disp_dest_idx, disp_rs1_idx, disp_rs2_idx,
	output logic                 disp_rs1_used, disp_rs2_used,
	output logic                 disp_rd_mem, disp_wr_mem,
	output logic                 disp_cond_branch, disp_uncond_branch,
	output logic                 disp_mult_op, disp_csr_op,
	output logic                 disp_halt, disp_illegal,
	output logic                 disp_pred_taken,
	output logic [dirp_bits-1:0] disp_dirp_idx
);

	localparam int cnt_bits = $clog2(dispatch_credits + 1);

	logic [xlen-1:0]     pc_reg;
	logic [cnt_bits-1:0] credit_cnt;
	logic                halted;
	logic                dest_used;

	//////////////////////////////////////////////////
	// fetch

	// memory returns 8-byte words
	assign imem_addr = {pc_reg[xlen-1:3], 3'b0};
	assign disp_inst = pc_reg[2] ? imem_data[63:32] : imem_data[31:0];
	assign seq_pc    = pc_reg + 32'd4;
	assign fetch_pc  = pc_reg;

	inst_decoder decoder_0 (
		.inst(disp_inst),
		.opa_select(disp_opa_select),
		.opb_select(disp_opb_select),
		.alu_func(disp_alu_func),
		.dest_used(dest_used),
		.rs1_used(disp_rs1_used),
		.rs2_used(disp_rs2_used),
		.rd_mem(disp_rd_mem),
		.wr_mem(disp_wr_mem),
		.cond_branch(disp_cond_branch),
		.uncond_branch(disp_uncond_branch),
		.mult_op(disp_mult_op),
		.csr_op(disp_csr_op),
		.halt(disp_halt),
		.illegal(disp_illegal)
	);

	// branch kind for prediction
	assign is_cond_branch = disp_cond_branch;
	assign is_jump        = disp_uncond_branch;

	// register indices are x0 when unused
	assign disp_dest_idx = dest_used ? disp_inst[11:7] : 5'd0;
	assign disp_rs1_idx  = disp_rs1_used ? disp_inst[19:15] : 5'd0;
	assign disp_rs2_idx  = disp_rs2_used ? disp_inst[24:20] : 5'd0;

	//////////////////////////////////////////////////
	// dispatch

	// nothing leaves in reset
	// squash has priority and credits are the only back-pressure
	assign disp_valid = !reset && imem_valid && (credit_cnt != '0) && !squash && !halted;

	assign disp_pc         = pc_reg;
	assign disp_npc        = pred_next_pc;
	assign disp_pred_taken = pred_taken_in;
	assign disp_dirp_idx   = dirp_idx_in;

	always_ff @(posedge clock) begin
		if (reset)
			pc_reg <= '0;
		else if (squash)
			pc_reg <= squash_pc;
		else if (disp_valid)
			pc_reg <= pred_next_pc;
	end

	// halt stops fetch until the rob redirects
	always_ff @(posedge clock) begin
		if (reset || squash)
			halted <= 1'b0;
		else if (disp_valid && disp_halt)
			halted <= 1'b1;
	end

	// one credit per dispatch and one back per return pulse
	always_ff @(posedge clock) begin
		if (reset)
			credit_cnt <= cnt_bits'(dispatch_credits);
		else begin
			case ({disp_valid, credit_return})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// credit protocol checks

	assert property (@(posedge clock) disable iff (reset)
		credit_cnt <= cnt_bits'(dispatch_credits));

	// downstream cannot return more than it was given
	assert property (@(posedge clock) disable iff (reset)
		credit_return |-> (credit_cnt < cnt_bits'(dispatch_credits)));

endmodule

/* rtl/frontend_pkg.sv */
//////////////////////////////////////////////////
// front end shared width, select and alu enums
// rv32 opcode, funct3 and funct7 constants
//////////////////////////////////////////////////

package frontend_pkg;

	parameter int xlen = 32;

	// operand a source
	typedef enum logic [1:0] {opa_is_rs1, opa_is_pc, opa_is_zero} opa_sel_e;

	// operand b source
	typedef enum logic [2:0] {
		opb_is_rs2, opb_is_i_imm, opb_is_s_imm, opb_is_b_imm, opb_is_u_imm, opb_is_j_imm
	} opb_sel_e;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_or, alu_xor,
		alu_sll, alu_srl, alu_sra, alu_mul, alu_mulh, alu_mulhsu, alu_mulhu
	} alu_func_e;

	//////////////////////////////////////////////////
	// major opcodes
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_reg    = 7'b0110011;
	localparam logic [6:0] op_system = 7'b1110011;

	// alu funct3, the remaining code is and
	localparam logic [2:0] f3_add  = 3'b000;
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_sr   = 3'b101;
	localparam logic [2:0] f3_or   = 3'b110;

	// multiply group, mulhu is the last code
	localparam logic [2:0] f3_mul    = 3'b000;
	localparam logic [2:0] f3_mulh   = 3'b001;
	localparam logic [2:0] f3_mulhsu = 3'b010;

	// load/store width codes
	localparam logic [2:0] f3_byte   = 3'b000;
	localparam logic [2:0] f3_half   = 3'b001;
	localparam logic [2:0] f3_word   = 3'b010;
	localparam logic [2:0] f3_byte_u = 3'b100;
	localparam logic [2:0] f3_half_u = 3'b101;

	// csr register forms
	localparam logic [2:0] f3_csrrw = 3'b001;
	localparam logic [2:0] f3_csrrs = 3'b010;
	localparam logic [2:0] f3_csrrc = 3'b011;

	localparam logic [6:0] f7_base   = 7'b0000000;
	localparam logic [6:0] f7_alt    = 7'b0100000;
	localparam logic [6:0] f7_muldiv = 7'b0000001;

	// wait-for-interrupt, used as halt
	localparam logic [31:0] wfi_inst = 32'h10500073;

endpackage

/* rtl/frontend_top.sv */
//////////////////////////////////////////////////
// front end top, dispatch plus next-pc logic
//////////////////////////////////////////////////

`timescale 1ns/1ps

module frontend_top import frontend_pkg::*; #(
	parameter int dispatch_credits = 4,
	parameter int pht_entries = 64,
	parameter int btb_entries = 16,
	localparam int dirp_bits = $clog2(pht_entries)
) (
	input  logic                 clock,
	input  logic                 reset,
	output logic [xlen-1:0]      imem_addr,
	input  logic [63:0]          imem_data,
	input  logic                 imem_valid,
	input  logic                 squash,
	input  logic [xlen-1:0]      squash_pc,
	input  logic                 credit_return,
	input  logic                 resolve_valid,
	input  logic [xlen-1:0]      resolve_pc,
	input  logic [xlen-1:0]      resolve_target,
	input  logic                 resolve_taken,
	input  logic                 resolve_is_branch,
	input  logic [dirp_bits-1:0] resolve_dirp_idx,
	output logic                 disp_valid,
	output logic [xlen-1:0]      disp_pc,
	output logic [xlen-1:0]      disp_npc,
	output logic [31:0]          disp_inst,
	output opa_sel_e             disp_opa_select,
	output opb_sel_e             disp_opb_select,
	output alu_func_e            disp_alu_func,
	output logic [4:0]           disp_dest_idx, disp_rs1_idx, disp_rs2_idx,
	output logic                 disp_rs1_used, disp_rs2_used,
	output logic                 disp_rd_mem, disp_wr_mem,
	output logic                 disp_cond_branch, disp_uncond_branch,
	output logic                 disp_mult_op, disp_csr_op,
	output logic                 disp_halt, disp_illegal,
	output logic                 disp_pred_taken,
	output logic [dirp_bits-1:0] disp_dirp_idx
);

	// fetch side <-> predictor
	logic [xlen-1:0]      fetch_pc;
	logic [xlen-1:0]      seq_pc;
	logic                 is_cond_branch;
	logic                 is_jump;
	logic [xlen-1:0]      pred_next_pc;
	logic                 pred_taken;
	logic [dirp_bits-1:0] dirp_idx;

	dispatch_stage #(
		.dispatch_credits(dispatch_credits),
		.pht_entries(pht_entries)
	) dispatch_0 (
		.pred_taken_in(pred_taken),
		.dirp_idx_in(dirp_idx),
		.*
	);

	next_pc_logic #(
		.pht_entries(pht_entries),
		.btb_entries(btb_entries)
	) npc_0 (
		.*
	);

endmodule

/* rtl/inst_decoder.sv */
//////////////////////////////////////////////////
// combinational rv32im decoder
//////////////////////////////////////////////////

`timescale 1ns/1ps

module inst_decoder import frontend_pkg::*; (
	input  logic [31:0] inst,
	output opa_sel_e    opa_select,
	output opb_sel_e    opb_select,
	output alu_func_e   alu_func,
	output logic        dest_used, rs1_used, rs2_used,
	output logic        rd_mem, wr_mem, cond_branch, uncond_branch,
	output logic        mult_op, csr_op, halt, illegal
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	// base alu op from funct3, alt picks sub/sra
	function automatic alu_func_e base_alu(input logic [2:0] f3, input logic alt);
		alu_func_e f;
		case (f3)
			f3_add:  f = alt ? alu_sub : alu_add;
			f3_sll:  f = alu_sll;
			f3_slt:  f = alu_slt;
			f3_sltu: f = alu_sltu;
			f3_xor:  f = alu_xor;
			f3_sr:   f = alt ? alu_sra : alu_srl;
			f3_or:   f = alu_or;
			default: f = alu_and;
		endcase
		return f;
	endfunction

	always_comb begin
		// no-op defaults
		opa_select    = opa_is_rs1;
		opb_select    = opb_is_rs2;
		alu_func      = alu_add;
		dest_used     = 1'b0;
		rs1_used      = 1'b0;
		rs2_used      = 1'b0;
		rd_mem        = 1'b0;
		wr_mem        = 1'b0;
		cond_branch   = 1'b0;
		uncond_branch = 1'b0;
		mult_op       = 1'b0;
		csr_op        = 1'b0;
		halt          = 1'b0;
		illegal       = 1'b0;
		case (opcode)
			op_lui, op_auipc: begin
				dest_used  = 1'b1;
				opa_select = (opcode == op_lui) ? opa_is_zero : opa_is_pc;
				opb_select = opb_is_u_imm;
			end
			op_jal: begin
				dest_used     = 1'b1;
				opa_select    = opa_is_pc;
				opb_select    = opb_is_j_imm;
				uncond_branch = 1'b1;
			end
			op_jalr: begin
				illegal       = (funct3 != 3'b000);
				dest_used     = !illegal;
				rs1_used      = !illegal;
				opb_select    = opb_is_i_imm;
				uncond_branch = !illegal;
			end
			op_branch: begin
				// funct3 010/011 are unassigned
				illegal     = (funct3[2:1] == 2'b01);
				rs1_used    = !illegal;
				rs2_used    = !illegal;
				opa_select  = opa_is_pc;
				opb_select  = opb_is_b_imm;
				cond_branch = !illegal;
			end
			op_load: begin
				illegal    = !(funct3 inside {f3_byte, f3_half, f3_word, f3_byte_u, f3_half_u});
				dest_used  = !illegal;
				rs1_used   = !illegal;
				opb_select = opb_is_i_imm;
				rd_mem     = !illegal;
			end
			op_store: begin
				illegal    = !(funct3 inside {f3_byte, f3_half, f3_word});
				rs1_used   = !illegal;
				rs2_used   = !illegal;
				opb_select = opb_is_s_imm;
				wr_mem     = !illegal;
			end
			op_imm: begin
				// shift immediates carry funct7 in the upper bits
				if (funct3 == f3_sll)
					illegal = (funct7 != f7_base);
				else if (funct3 == f3_sr)
					illegal = !(funct7 inside {f7_base, f7_alt});
				dest_used  = !illegal;
				rs1_used   = !illegal;
				opb_select = opb_is_i_imm;
				alu_func   = base_alu(funct3, (funct3 == f3_sr) && funct7[5]);
			end
			op_reg: begin
				if (funct7 == f7_muldiv && !funct3[2]) begin
					// m group, divides not supported
					mult_op = 1'b1;
					case (funct3)
						f3_mul:    alu_func = alu_mul;
						f3_mulh:   alu_func = alu_mulh;
						f3_mulhsu: alu_func = alu_mulhsu;
						default:   alu_func = alu_mulhu;
					endcase
				end else if (funct7 == f7_base ||
					(funct7 == f7_alt && funct3 inside {f3_add, f3_sr})) begin
					alu_func = base_alu(funct3, funct7[5]);
				end else begin
					illegal = 1'b1;
				end
				dest_used = !illegal;
				rs1_used  = !illegal;
				rs2_used  = !illegal;
			end
			op_system: begin
				if (inst == wfi_inst)
					halt = 1'b1;
				else if (funct3 inside {f3_csrrw, f3_csrrs, f3_csrrc}) begin
					csr_op   = 1'b1;
					rs1_used = 1'b1;
				end else
					illegal = 1'b1;
			end
			default: illegal = 1'b1;
		endcase
	end

endmodule

/* rtl/next_pc_logic.sv */
//////////////////////////////////////////////////
// next pc prediction from counters and btb
//////////////////////////////////////////////////

`timescale 1ns/1ps

module next_pc_logic import frontend_pkg::*; #(
	parameter int pht_entries = 64,
	parameter int btb_entries = 16,
	localparam int dirp_bits = $clog2(pht_entries)
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic [xlen-1:0]      fetch_pc,
	input  logic [xlen-1:0]      seq_pc,
	input  logic                 is_cond_branch,
	input  logic                 is_jump,
	output logic [xlen-1:0]      pred_next_pc,
	output logic                 pred_taken,
	output logic [dirp_bits-1:0] dirp_idx,
	input  logic                 resolve_valid,
	input  logic [xlen-1:0]      resolve_pc,
	input  logic [xlen-1:0]      resolve_target,
	input  logic                 resolve_taken,
	input  logic                 resolve_is_branch,
	input  logic [dirp_bits-1:0] resolve_dirp_idx
);

	logic            predict_taken;
	logic            btb_hit;
	logic [xlen-1:0] btb_target;

	direction_predictor #(.pht_entries(pht_entries)) dirp_0 (
		.clock(clock),
		.reset(reset),
		.fetch_pc(fetch_pc),
		.dirp_idx(dirp_idx),
		.predict_taken(predict_taken),
		// only conditional branches train the counters
		.train_valid(resolve_valid && resolve_is_branch),
		.train_idx(resolve_dirp_idx),
		.train_taken(resolve_taken)
	);

	branch_target_buffer #(.btb_entries(btb_entries)) btb_0 (
		.clock(clock),
		.reset(reset),
		.lookup_pc(fetch_pc),
		.hit(btb_hit),
		.target(btb_target),
		// any taken control transfer
		.write_valid(resolve_valid && resolve_taken),
		.write_pc(resolve_pc),
		.write_target(resolve_target)
	);

	// jumps always predicted taken
	assign pred_taken = (is_cond_branch && predict_taken) || is_jump;

	// no target known yet -> fall through
	assign pred_next_pc = (pred_taken && btb_hit) ? btb_target : seq_pc;

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f compile.f --top-module frontend_tb -o frontend_sim &&
./obj_dir/frontend_sim | tee /dev/stderr | grep -q "All tests passed" || exit 1

/* test/frontend_tb.sv */
//////////////////////////////////////////////////
// front end testbench, memory model, reference
// rules for pc, credits and prediction, checks
//////////////////////////////////////////////////

`timescale 1ns/1ps

module frontend_tb import frontend_pkg::*; ();

	localparam int credits_max = 4;
	localparam int num_rows = 19;
	localparam int num_cols = 9;
	localparam int wait_limit = 200;

	logic                clock;
	logic                reset;
	logic [xlen-1:0]     imem_addr;
	logic [63:0]         imem_data;
	logic                imem_valid;
	logic                squash;
	logic [xlen-1:0]     squash_pc;
	logic                credit_return;
	logic                resolve_valid;
	logic [xlen-1:0]     resolve_pc;
	logic [xlen-1:0]     resolve_target;
	logic                resolve_taken;
	logic                resolve_is_branch;
	logic [5:0]          resolve_dirp_idx;
	logic                disp_valid;
	logic [xlen-1:0]     disp_pc, disp_npc;
	logic [31:0]         disp_inst;
	opa_sel_e            disp_opa_select;
	opb_sel_e            disp_opb_select;
	alu_func_e           disp_alu_func;
	logic [4:0]          disp_dest_idx, disp_rs1_idx, disp_rs2_idx;
	logic                disp_rs1_used, disp_rs2_used, disp_rd_mem, disp_wr_mem;
	logic                disp_cond_branch, disp_uncond_branch, disp_mult_op, disp_csr_op;
	logic                disp_halt, disp_illegal, disp_pred_taken;
	logic [5:0]          disp_dirp_idx;

	frontend_top #(
		.dispatch_credits(credits_max),
		.pht_entries(64),
		.btb_entries(16)
	) DUT (.*);

	// test data has one row of num_cols words per instruction
	logic [31:0] td [num_rows*num_cols];
	logic [63:0] mem [64];

	// reference model state
	logic [31:0] m_pc;
	int          credits;
	logic        m_halted;
	logic [1:0]  m_pht [64];
	logic        m_btb_valid [16];
	logic [31:0] m_btb_pc [16];
	logic [31:0] m_btb_target [16];
	logic [31:0] rng_state;
	int          errors;

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic rand_bit();
		rng_state = xorshift(rng_state);
		return rng_state[7];
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			errors++;
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic fail_plain(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1);
	endtask

	//////////////////////////////////////////////////
	// reference rules per dispatch

	// compares one dispatch with its data row and returns the expected npc
	task automatic check_dispatch(output logic [31:0] exp_npc);
		int          r;
		int          idx;
		int          b;
		logic        exp_taken;
		logic        row_cond;
		logic [31:0] flags;
		r = -1;
		for (int i = 0; i < num_rows; i++)
			if (td[i*num_cols] == m_pc)
				r = i;
		if (r < 0)
			fail_plain("dispatch at an address with no test data row");
		check_val("disp_pc", m_pc, disp_pc);
		check_val("disp_inst", td[r*num_cols+1], disp_inst);
		check_val("opa_select", td[r*num_cols+2], 32'(disp_opa_select));
		check_val("opb_select", td[r*num_cols+3], 32'(disp_opb_select));
		check_val("alu_func", td[r*num_cols+4], 32'(disp_alu_func));
		check_val("dest_idx", td[r*num_cols+5], 32'(disp_dest_idx));
		check_val("rs1_idx", td[r*num_cols+6], 32'(disp_rs1_idx));
		check_val("rs2_idx", td[r*num_cols+7], 32'(disp_rs2_idx));
		flags = td[r*num_cols+8];
		check_val("flags", flags, {22'b0, disp_rs1_used, disp_rs2_used, disp_rd_mem,
			disp_wr_mem, disp_cond_branch, disp_uncond_branch, disp_mult_op,
			disp_csr_op, disp_halt, disp_illegal});
		// prediction from the modelled counter and target table
		idx = m_pc[7:2];
		b = m_pc[5:2];
		row_cond = flags[5];
		exp_taken = (row_cond && m_pht[idx][1]) || flags[4];
		if (exp_taken && m_btb_valid[b] && m_btb_pc[b][31:6] == m_pc[31:6])
			exp_npc = m_btb_target[b];
		else
			exp_npc = m_pc + 32'd4;
		check_val("dirp_idx", idx, 32'(disp_dirp_idx));
		check_val("pred_taken", exp_taken, disp_pred_taken);
		check_val("disp_npc", exp_npc, disp_npc);
		if (flags[1])
			m_halted = 1'b1;
	endtask

	// one cycle with inputs on the falling edge and outputs sampled 1 ns later
	task automatic step(input logic valid, input logic ret, input logic sq,
		input logic [31:0] sq_pc);
		logic        exp_valid;
		logic [31:0] exp_npc;
		@(negedge clock);
		imem_valid    = valid;
		imem_data     = mem[imem_addr[8:3]];
		credit_return = ret;
		squash        = sq;
		squash_pc     = sq_pc;
		resolve_valid = 1'b0;
		#1;
		check_val("imem_addr", {m_pc[31:3], 3'b0}, imem_addr);
		exp_valid = valid && (credits != 0) && !sq && !m_halted;
		check_val("disp_valid", exp_valid, disp_valid);
		exp_npc = m_pc;
		if (disp_valid)
			check_dispatch(exp_npc);
		if (sq) begin
			m_pc = sq_pc;
			m_halted = 1'b0;
		end else if (disp_valid)
			m_pc = exp_npc;
		credits = credits + int'(ret) - int'(disp_valid);
	endtask

	// random memory gaps and credit returns until the next dispatch
	task automatic dispatch_at(input logic [31:0] exp_pc);
		int  t;
		logic v;
		logic r;
		for (t = 0; t < wait_limit; t++) begin
			v = rand_bit();
			r = (credits < credits_max) && rand_bit();
			step(v, r, 1'b0, 32'h0);
			if (disp_valid)
				break;
		end
		if (t == wait_limit)
			fail_plain("timeout waiting for a dispatch");
		check_val("dispatch order", exp_pc, disp_pc);
	endtask

	task automatic refill_credits();
		int t;
		for (t = 0; t < wait_limit && credits < credits_max; t++)
			step(1'b0, 1'b1, 1'b0, 32'h0);
		if (credits < credits_max)
			fail_plain("timeout while returning credits");
	endtask

	task automatic resolve(input logic [31:0] pc, input logic [31:0] target,
		input logic taken, input logic [5:0] idx);
		@(negedge clock);
		imem_valid        = 1'b0;
		credit_return     = 1'b0;
		squash            = 1'b0;
		resolve_valid     = 1'b1;
		resolve_pc        = pc;
		resolve_target    = target;
		resolve_taken     = taken;
		resolve_is_branch = 1'b1;
		resolve_dirp_idx  = idx;
		#1;
		// counter saturates and a taken resolve writes the target entry
		if (taken && m_pht[idx] != 2'b11)
			m_pht[idx] = m_pht[idx] + 2'd1;
		else if (!taken && m_pht[idx] != 2'b00)
			m_pht[idx] = m_pht[idx] - 2'd1;
		if (taken) begin
			m_btb_valid[pc[5:2]]  = 1'b1;
			m_btb_pc[pc[5:2]]     = pc;
			m_btb_target[pc[5:2]] = target;
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence

	initial begin
		int          count;
		logic [5:0]  br_idx;
		reset = 1'b1;
		imem_valid = 1'b0;
		imem_data = '0;
		squash = 1'b0;
		squash_pc = '0;
		credit_return = 1'b0;
		resolve_valid = 1'b0;
		resolve_pc = '0;
		resolve_target = '0;
		resolve_taken = 1'b0;
		resolve_is_branch = 1'b0;
		resolve_dirp_idx = '0;
		errors = 0;
		rng_state = 32'he8c9;
		m_pc = '0;
		credits = credits_max;
		m_halted = 1'b0;
		for (int i = 0; i < 64; i++)
			m_pht[i] = 2'b01;
		for (int i = 0; i < 16; i++)
			m_btb_valid[i] = 1'b0;

		// address-dependent fill and then the program image
		for (int i = 0; i < 64; i++)
			mem[i] = {32'(i*8+4) ^ 32'h5a5a0000, 32'(i*8) ^ 32'h5a5a0000};
		$readmemh("test/frontend_testdata.txt", td);
		for (int i = 0; i < num_rows; i++) begin
			if (td[i*num_cols][2])
				mem[td[i*num_cols][8:3]][63:32] = td[i*num_cols+1];
			else
				mem[td[i*num_cols][8:3]][31:0] = td[i*num_cols+1];
		end

		// reset held for 3 cycles with memory valid
		repeat (3) begin
			@(negedge clock);
			imem_valid = 1'b1;
			imem_data  = mem[0];
			#1;
			check_val("disp_valid in reset", 0, disp_valid);
		end
		reset = 1'b0;
		imem_valid = 1'b0;
		check_val("imem_addr after reset", 0, imem_addr);

		// straight-line decode with random gaps
		for (int r = 0; r < 16; r++)
			dispatch_at(32'(r*4));

		// squash with memory valid dispatches nothing
		refill_credits();
		step(1'b1, 1'b0, 1'b1, 32'h0);

		// credits without returns
		count = 0;
		for (int i = 0; i < credits_max + 4; i++) begin
			step(1'b1, 1'b0, 1'b0, 32'h0);
			count += int'(disp_valid);
		end
		check_val("dispatches without returns", credits_max, count);
		step(1'b1, 1'b1, 1'b0, 32'h0);
		count = 0;
		repeat (3) begin
			step(1'b1, 1'b0, 1'b0, 32'h0);
			count += int'(disp_valid);
		end
		check_val("dispatches per returned credit", 1, count);

		// squash redirect
		refill_credits();
		step(1'b1, 1'b0, 1'b1, 32'h20);
		dispatch_at(32'h20);

		// branch before and after training
		step(1'b1, 1'b0, 1'b1, 32'h40);
		dispatch_at(32'h40);
		check_val("pred_taken untrained", 0, disp_pred_taken);
		check_val("npc untrained", 32'h44, disp_npc);
		// word index of the branch
		br_idx = 6'h10;
		resolve(32'h40, 32'h60, 1'b1, br_idx);
		step(1'b1, 1'b0, 1'b1, 32'h40);
		dispatch_at(32'h40);
		check_val("pred_taken trained", 1, disp_pred_taken);
		check_val("npc trained", 32'h60, disp_npc);
		dispatch_at(32'h60);
		check_val("disp_illegal", 1, disp_illegal);

		// halt stops fetch until a squash
		dispatch_at(32'h64);
		check_val("disp_halt", 1, disp_halt);
		count = 0;
		repeat (8) begin
			step(1'b1, credits < credits_max, 1'b0, 32'h0);
			count += int'(disp_valid);
		end
		check_val("dispatches after halt", 0, count);
		step(1'b1, 1'b0, 1'b1, 32'h0);
		dispatch_at(32'h0);

		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* test/frontend_testdata.txt */
// addr inst opa opb alu dest rs1 rs2 flags
// flags: rs1_used rs2_used rd_mem wr_mem cond uncond mult csr halt illegal (bit 9 down to 0)
00000000 00500093 0 1 0 01 00 00 200
00000004 00700113 0 1 0 02 00 00 200
00000008 002081b3 0 0 0 03 01 02 300
0000000c 40118233 0 0 1 04 03 01 300
00000010 123452b7 2 4 0 05 00 00 000
00000014 00001317 1 4 0 06 00 00 000
00000018 0080a383 0 1 0 07 01 00 280
0000001c 0020a623 0 2 0 00 01 02 340
00000020 02208433 0 0 a 08 01 02 308
00000024 0241b4b3 0 0 d 09 03 04 308
00000028 00309513 0 1 7 0a 01 00 200
0000002c 4020d593 0 1 9 0b 01 00 200
00000030 0020c633 0 0 6 0c 01 02 300
00000034 0020b6b3 0 0 3 0d 01 02 300
00000038 3000a773 0 0 0 00 01 00 204
0000003c 0020e7b3 0 0 5 0f 01 02 300
00000040 02208063 1 3 0 00 01 02 320
00000060 ffffffff 0 0 0 00 00 00 001
00000064 10500073 0 0 0 00 00 00 002
